// ==== cabinet/s16_cab_io.sv ====
// cabinet inputs and 8255 ports
`timescale 1ns/1ps

module s16_cab_io import s16_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  bus_req_t   bus,
    input  logic       io_cs,
    input  cab_in_t    cab,
    input  logic       snd_ack,
    output logic [7:0] cab_dout,
    output logic [7:0] snd_latch,
    output logic       snd_irqn,
    output logic       flip
);

    logic [7:0] ppi_ctrl;   // 8255 control word, kept for read back
    logic [7:0] rd_data;
    logic       wr_en;
    io_port_e   port;

    // board wiring of the joystick lines
    function automatic logic [7:0] sort_joy(input logic [7:0] j);
        sort_joy = {j[1], j[0], j[3], j[2], j[7], j[5], j[4], j[6]};
    endfunction

    assign port  = io_port_e'(bus.addr[2:1]);
    assign wr_en = io_cs & ~bus.rnw & ~bus.lds_n;  // low byte only

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_latch <= 8'd0;
            snd_irqn  <= 1'b1;
            flip      <= 1'b0;
            ppi_ctrl  <= PPI_CTRL_RESET;
        end else if (wr_en && bus.addr[13:12] == 2'd0) begin
            case (port)
                PORT_A:    snd_latch <= bus.dout[7:0];
                PORT_B:    flip      <= bus.dout[7];
                PORT_C:    snd_irqn  <= bus.dout[7];
                PORT_CTRL: ppi_ctrl  <= bus.dout[7:0];
                default:   ppi_ctrl  <= ppi_ctrl;
            endcase
        end
    end

    always_comb begin
        rd_data = 8'hff;
        case (bus.addr[13:12])
            2'd0: begin
                case (port)
                    PORT_A:    rd_data = snd_latch;
                    PORT_B:    rd_data = {flip, 7'h7f};
                    PORT_C:    rd_data = {snd_irqn, snd_ack, 6'h3f};
                    PORT_CTRL: rd_data = ppi_ctrl;
                    default:   rd_data = 8'hff;
                endcase
            end
            2'd1: begin
                case (bus.addr[2:1])
                    2'd0:    rd_data = {2'b11, cab.start, cab.service, 1'b1, cab.coin};
                    2'd1:    rd_data = sort_joy(cab.joy1);
                    2'd3:    rd_data = sort_joy(cab.joy2);
                    default: rd_data = 8'hff;
                endcase
            end
            2'd2: begin
                rd_data = bus.addr[1] ? cab.dipsw_b : cab.dipsw_a;
            end
            default: rd_data = 8'hff;
        endcase
    end

    // follows the address every cycle so the byte is ready before the ack
    always_ff @(posedge clk) begin
        cab_dout <= rd_data;
    end

endmodule

// ==== common/s16_pkg.sv ====
// main cpu bus definitions
package s16_pkg;

    // vertical blank request line
    localparam int unsigned VBLANK_LINE = 223;

    localparam logic [7:0]  PPI_CTRL_RESET = 8'h9b;  // 8255 mode word after reset
    localparam logic [15:0] OPEN_BUS       = 16'hffff;

    // page codes from addr[18:16], each with its addr[23:22] code
    localparam logic [2:0] PAGE_VRAM = 3'd0;
    localparam logic [1:0] TOP_VRAM  = 2'd1;
    localparam logic [2:0] PAGE_CHR  = 3'd1;
    localparam logic [1:0] TOP_CHR   = 2'd1;
    localparam logic [2:0] PAGE_OBJ  = 3'd4;
    localparam logic [1:0] TOP_OBJ   = 2'd1;
    localparam logic [2:0] PAGE_PAL  = 3'd4;
    localparam logic [1:0] TOP_PAL   = 2'd2;
    localparam logic [2:0] PAGE_IO   = 3'd4;
    localparam logic [1:0] TOP_IO    = 2'd3;
    localparam logic [2:0] PAGE_WDOG = 3'd6;
    localparam logic [1:0] TOP_WDOG  = 2'd3;
    localparam logic [2:0] PAGE_RAM  = 3'd7;
    localparam logic [1:0] TOP_RAM   = 2'd3;
    localparam logic [1:0] TOP_ROM   = 2'd0;  // rom ignores the page bits

    typedef enum logic [3:0] {
        REG_NONE, REG_ROM, REG_VRAM, REG_CHR, REG_OBJ,
        REG_PAL, REG_IO, REG_WDOG, REG_RAM
    } region_e;

    typedef enum logic [1:0] {
        PORT_A, PORT_B, PORT_C, PORT_CTRL
    } io_port_e;

    typedef enum logic [1:0] {
        ACK_IDLE, ACK_WAIT, ACK_DONE, ACK_HOLD
    } ack_state_e;

    // cpu side of the bus, word addressed
    typedef struct packed {
        logic [23:1] addr;
        logic        as_n;
        logic        uds_n;
        logic        lds_n;
        logic        rnw;
        logic [15:0] dout;
        logic [2:0]  fc;
    } bus_req_t;

    typedef struct packed {
        logic rom;
        logic vram;
        logic chr;
        logic obj;
        logic pal;
        logic io;
        logic wdog;
        logic ram;
    } chip_sel_t;

    typedef struct packed {
        logic [7:0] joy1;
        logic [7:0] joy2;
        logic [1:0] start;
        logic [1:0] coin;
        logic       service;
        logic [7:0] dipsw_a;
        logic [7:0] dipsw_b;
    } cab_in_t;

endpackage

// ==== decode/s16_addr_decode.sv ====
// memory map decoder
`timescale 1ns/1ps

module s16_addr_decode import s16_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  bus_req_t    bus,
    output chip_sel_t   sel,
    output region_e     region,
    output logic [16:0] rom_addr,
    output logic [11:0] ram_addr
);

    chip_sel_t sel_nxt;
    logic      ds_valid;   // write cycles need a data strobe first

    assign rom_addr = bus.addr[17:1];
    assign ram_addr = bus.addr[12:1];

    assign ds_valid = bus.rnw | ~(bus.uds_n & bus.lds_n);

    always_comb begin
        region = REG_NONE;
        if (bus.addr[23:22] == TOP_ROM) begin
            region = REG_ROM;  // 000000-3fffff
        end else begin
            case ({bus.addr[23:22], bus.addr[18:16]})
                {TOP_VRAM, PAGE_VRAM}: region = REG_VRAM;
                {TOP_CHR, PAGE_CHR}:   region = REG_CHR;
                {TOP_OBJ, PAGE_OBJ}:   region = REG_OBJ;
                {TOP_PAL, PAGE_PAL}:   region = REG_PAL;
                {TOP_IO, PAGE_IO}:     region = REG_IO;
                {TOP_WDOG, PAGE_WDOG}: region = REG_WDOG;
                {TOP_RAM, PAGE_RAM}:   region = REG_RAM;
                default:               region = REG_NONE;
            endcase
        end
    end

    always_comb begin
        sel_nxt = '0;
        case (region)
            REG_ROM:  sel_nxt.rom  = 1'b1;
            REG_VRAM: sel_nxt.vram = ds_valid;  // byte enables must be valid
            REG_CHR:  sel_nxt.chr  = 1'b1;
            REG_OBJ:  sel_nxt.obj  = 1'b1;
            REG_PAL:  sel_nxt.pal  = 1'b1;
            REG_IO:   sel_nxt.io   = 1'b1;
            REG_WDOG: sel_nxt.wdog = 1'b1;
            REG_RAM:  sel_nxt.ram  = ds_valid;
            default:  sel_nxt = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= '0;
        end else if (bus.as_n) begin
            sel <= '0;  // released right after the strobe
        end else begin
            sel <= sel_nxt;
        end
    end

    // never more than one device on the bus
    a_sel_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(sel));

endmodule

// ==== hdl/s16_bus_return.sv ====
// read data return and dtack
`timescale 1ns/1ps

module s16_bus_return import s16_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  bus_req_t    bus,
    input  chip_sel_t   sel,
    input  logic [7:0]  cab_dout,
    input  logic [15:0] ram_data,
    input  logic [15:0] rom_data,
    input  logic [15:0] chr_dout,
    input  logic [15:0] obj_dout,
    input  logic [15:0] pal_dout,
    input  logic        rom_ok,
    input  logic        ram_ok,
    output logic [15:0] cpu_din,
    output logic        dtack_n
);

    ack_state_e  state;
    logic [15:0] rd_mux;
    logic        strb_q;    // data strobes valid as of last edge
    logic        busy;      // selected memory not ready yet

    always_comb begin
        if (sel.ram || sel.vram) begin
            rd_mux = ram_data;
        end else if (sel.rom) begin
            rd_mux = rom_data;
        end else if (sel.chr) begin
            rd_mux = chr_dout;
        end else if (sel.pal) begin
            rd_mux = pal_dout;
        end else if (sel.obj) begin
            rd_mux = obj_dout;
        end else if (sel.io) begin
            rd_mux = {8'hff, cab_dout};  // 8-bit port on the low lane
        end else begin
            rd_mux = OPEN_BUS;
        end
    end

    assign busy = (sel.rom & ~rom_ok) | ((sel.ram | sel.vram) & ~ram_ok);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ACK_IDLE;
            dtack_n <= 1'b1;
            strb_q  <= 1'b0;
        end else begin
            strb_q <= bus.rnw | ~(bus.uds_n & bus.lds_n);
            case (state)
                ACK_IDLE: begin
                    if (!bus.as_n) state <= ACK_WAIT;
                end
                ACK_WAIT: begin
                    // ram/vram selects wait on the data strobes of a write
                    if (bus.as_n) begin
                        state <= ACK_IDLE;
                    end else if (strb_q && !busy) begin
                        state   <= ACK_HOLD;
                        dtack_n <= 1'b0;
                    end
                end
                ACK_HOLD: begin
                    if (bus.as_n) begin
                        state   <= ACK_DONE;
                        dtack_n <= 1'b1;
                    end
                end
                ACK_DONE: begin
                    // sel is clearing now, a new strobe may already be low
                    state <= bus.as_n ? ACK_IDLE : ACK_WAIT;
                end
                default: state <= ACK_IDLE;
            endcase
        end
    end

    // loaded together with the ack and kept while dtack_n is low
    always_ff @(posedge clk) begin
        if (state == ACK_WAIT) begin
            cpu_din <= rd_mux;
        end
    end

    // the strobe was low at the edge that pulled dtack_n down
    a_dtack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        $fell(dtack_n) |-> !$past(bus.as_n));

endmodule

// ==== hdl/s16_main.sv ====
// main cpu bus logic top
`timescale 1ns/1ps

module s16_main import s16_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  bus_req_t    bus,
    // video timing
    input  logic [8:0]  vdump,
    input  logic        hstart,
    // memory read data
    input  logic [15:0] ram_data,   // shared by work ram and vram
    input  logic [15:0] rom_data,
    input  logic [15:0] chr_dout,
    input  logic [15:0] obj_dout,
    input  logic [15:0] pal_dout,
    input  logic        rom_ok,
    input  logic        ram_ok,
    input  cab_in_t     cab,
    input  logic        snd_ack,
    output chip_sel_t   sel,
    output logic [16:0] rom_addr,
    output logic [11:0] ram_addr,
    output logic [15:0] cpu_din,
    output logic        dtack_n,
    output logic        ipl2_n,
    output logic [7:0]  snd_latch,
    output logic        snd_irqn,
    output logic        flip
);

    logic [7:0] cab_dout;

    s16_addr_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .sel      (sel),
        .region   (),
        .rom_addr (rom_addr),
        .ram_addr (ram_addr)
    );

    s16_cab_io u_cab (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .io_cs     (sel.io),
        .cab       (cab),
        .snd_ack   (snd_ack),
        .cab_dout  (cab_dout),
        .snd_latch (snd_latch),
        .snd_irqn  (snd_irqn),
        .flip      (flip)
    );

    s16_bus_return u_ret (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .sel      (sel),
        .cab_dout (cab_dout),
        .ram_data (ram_data),
        .rom_data (rom_data),
        .chr_dout (chr_dout),
        .obj_dout (obj_dout),
        .pal_dout (pal_dout),
        .rom_ok   (rom_ok),
        .ram_ok   (ram_ok),
        .cpu_din  (cpu_din),
        .dtack_n  (dtack_n)
    );

    s16_vblank_irq u_irq (
        .clk    (clk),
        .rst    (rst),
        .bus    (bus),
        .vdump  (vdump),
        .hstart (hstart),
        .ipl2_n (ipl2_n)
    );

endmodule

// ==== hdl/s16_vblank_irq.sv ====
// vertical blank interrupt
`timescale 1ns/1ps

module s16_vblank_irq import s16_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  bus_req_t   bus,
    input  logic [8:0] vdump,
    input  logic       hstart,
    output logic       ipl2_n
);

    logic hstart_l;
    logic inta;

    assign inta = (&bus.fc) & ~bus.as_n;  // interrupt acknowledge cycle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ipl2_n   <= 1'b1;
            hstart_l <= 1'b0;
        end else begin
            hstart_l <= hstart;
            if (inta) begin
                ipl2_n <= 1'b1;   // ack has priority
            end else if (hstart && !hstart_l && vdump == 9'(VBLANK_LINE)) begin
                ipl2_n <= 1'b0;
            end
        end
    end

    a_ack_clears: assert property (@(posedge clk) disable iff (rst) inta |=> ipl2_n);

endmodule

// ==== project.f ====
+incdir+tests
common/s16_pkg.sv
decode/s16_addr_decode.sv
cabinet/s16_cab_io.sv
hdl/s16_bus_return.sv
hdl/s16_vblank_irq.sv
hdl/s16_main.sv
tests/tb_s16_main.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the main CPU bus testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_s16_main -o tb_s16_main
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_s16_main > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== tests/tb_s16_tasks.svh ====
// bus cycles and directed tests
`ifndef TB_S16_TASKS_SVH
`define TB_S16_TASKS_SVH

task automatic check_value(input string name, input logic [23:0] got, input logic [23:0] exp);
    assert (got === exp) else begin
        $display("Error %s: got %h, expected %h", name, got, exp);
        err_cnt++;
    end
endtask

task automatic report_test(input string name, input int e0);
    test_cnt++;
    if (err_cnt == e0) begin
        $display("test %s: ok", name);
    end else begin
        fail_cnt++;
        $display("test %s: %0d errors", name, err_cnt - e0);
    end
endtask

// one full strobe/dtack handshake, address held afterwards
task automatic bus_cycle(input logic [23:0] a, input logic rnw, input logic [15:0] wdata,
                         input logic [2:0] fc, output logic [15:0] rdata,
                         output logic [7:0] sel_seen, output int cycles);
    int waits;
    @(posedge clk);
    #2;
    mem_delay = $random(seed) & 7;
    bus.addr  = a[23:1];
    bus.rnw   = rnw;
    bus.dout  = wdata;
    bus.fc    = fc;
    bus.uds_n = 1'b0;
    bus.lds_n = 1'b0;
    bus.as_n  = 1'b0;
    cycles = 0;
    do begin
        @(posedge clk);
        #1;
        cycles++;
    end while (dtack_n && cycles < 20);
    assert (!dtack_n) else begin
        $display("no dtack for the bus cycle at %h within 20 cycles", a);
        err_cnt++;
    end
    rdata    = cpu_din;
    sel_seen = sel;
    #1;
    bus.as_n  = 1'b1;
    bus.uds_n = 1'b1;
    bus.lds_n = 1'b1;
    bus.rnw   = 1'b1;
    waits = 0;
    do begin
        @(posedge clk);
        #1;
        waits++;
    end while (!dtack_n && waits < 4);
    assert (waits <= 2) else begin
        $display("dtack_n stayed low %0d cycles after as_n rose", waits);
        err_cnt++;
    end
endtask

task automatic read_check(input logic [23:0] a, input logic [15:0] exp);
    logic [15:0] d;
    logic [7:0]  s;
    int          n;
    bus_cycle(a, 1'b1, 16'h0, 3'b101, d, s, n);
    check_value("cpu_din", 24'(d), 24'(exp));
endtask

task automatic write_io(input logic [23:0] a, input logic [7:0] data);
    logic [15:0] d;
    logic [7:0]  s;
    int          n;
    bus_cycle(a, 1'b0, {8'h00, data}, 3'b101, d, s, n);
endtask

task automatic map_read(input logic [23:0] a, input logic [7:0] exp_sel, input logic chk,
                        input logic [15:0] exp_d);
    logic [15:0] d;
    logic [7:0]  s;
    int          n;
    bus_cycle(a, 1'b1, 16'h0, 3'b101, d, s, n);
    check_value("sel", 24'(s), 24'(exp_sel));
    if (chk) begin
        check_value("cpu_din", 24'(d), 24'(exp_d));
    end
    if (!exp_sel[7] && !exp_sel[6] && !exp_sel[0]) begin
        check_value("dtack cycles", 24'(n), 24'd2);   // unwaited region
    end
endtask

// joystick lines as wired to the port, high bit first
function automatic logic [7:0] joy_wired(input logic [7:0] j);
    joy_wired = {j[1], j[0], j[3], j[2], j[7], j[5], j[4], j[6]};
endfunction

task automatic test_reset();
    int e0;
    e0 = err_cnt;
    check_value("sel", 24'(sel), 24'h0);
    check_value("dtack_n", 24'(dtack_n), 24'h1);
    check_value("ipl2_n", 24'(ipl2_n), 24'h1);
    check_value("snd_irqn", 24'(snd_irqn), 24'h1);
    check_value("flip", 24'(flip), 24'h0);
    check_value("snd_latch", 24'(snd_latch), 24'h0);
    report_test("reset", e0);
endtask

task automatic test_mem_reads();
    logic [23:0] a;
    logic [15:0] d;
    logic [7:0]  s;
    int          n;
    int          e0;
    int          i;
    e0 = err_cnt;
    for (i = 0; i < 8; i++) begin
        a = {2'b00, 21'($random(seed)), 1'b0};
        bus_cycle(a, 1'b1, 16'h0, 3'b110, d, s, n);
        check_value("cpu_din", 24'(d), 24'(rom_word(a[17:1])));
        check_value("rom_addr", 24'(rom_addr), 24'(a[17:1]));
        assert (n >= mem_delay + 2) else begin
            $display("rom read at %h ended after %0d cycles, before rom_ok", a, n);
            err_cnt++;
        end
        a = {8'hc7, 15'($random(seed)), 1'b0};
        bus_cycle(a, 1'b1, 16'h0, 3'b101, d, s, n);
        check_value("cpu_din", 24'(d), 24'(ram_word(a[12:1])));
        check_value("ram_addr", 24'(ram_addr), 24'(a[12:1]));
        assert (n >= mem_delay + 2) else begin
            $display("ram read at %h ended after %0d cycles, before ram_ok", a, n);
            err_cnt++;
        end
    end
    report_test("rom and ram reads", e0);
endtask

task automatic test_memory_map();
    int e0;
    e0 = err_cnt;
    map_read(24'h012346, 8'h80, 1'b0, 16'h0);       // rom
    map_read(24'h400100, 8'h40, 1'b0, 16'h0);       // vram
    map_read(24'h410010, 8'h20, 1'b1, CHR_TAG);
    map_read(24'h440020, 8'h10, 1'b1, OBJ_TAG);
    map_read(24'h840030, 8'h08, 1'b1, PAL_TAG);
    map_read(24'hc41000, 8'h04, 1'b0, 16'h0);       // cabinet i/o
    map_read(24'hc60000, 8'h02, 1'b0, 16'h0);       // watchdog
    map_read(24'hc70040, 8'h01, 1'b0, 16'h0);       // work ram
    map_read(24'h420000, 8'h00, 1'b1, 16'hffff);    // unmapped page
    report_test("memory map", e0);
endtask

task automatic test_cabinet_reads();
    int e0;
    int i;
    e0 = err_cnt;
    cab.coin    = 2'b10;
    cab.start   = 2'b01;
    cab.service = 1'b0;
    read_check(24'hc41000, {8'hff, 2'b11, 2'b01, 1'b0, 1'b1, 2'b10});
    for (i = 0; i < 4; i++) begin
        cab.joy1 = 8'($random(seed));
        cab.joy2 = 8'($random(seed));
        read_check(24'hc41002, {8'hff, joy_wired(cab.joy1)});
        read_check(24'hc41006, {8'hff, joy_wired(cab.joy2)});
    end
    cab.dipsw_a = 8'($random(seed));
    cab.dipsw_b = 8'($random(seed));
    read_check(24'hc42000, {8'hff, cab.dipsw_a});
    read_check(24'hc42002, {8'hff, cab.dipsw_b});
    report_test("cabinet reads", e0);
endtask

task automatic test_ppi_writes();
    int e0;
    e0 = err_cnt;
    read_check(24'hc40006, 16'hff9b);          // control word after reset
    write_io(24'hc40000, 8'h5a);
    check_value("snd_latch", 24'(snd_latch), 24'h5a);
    read_check(24'hc40000, 16'hff5a);
    write_io(24'hc40002, 8'h80);
    check_value("flip", 24'(flip), 24'h1);
    read_check(24'hc40002, 16'hffff);
    write_io(24'hc40002, 8'h00);
    check_value("flip", 24'(flip), 24'h0);
    read_check(24'hc40002, 16'hff7f);
    snd_ack = 1'b1;
    write_io(24'hc40004, 8'h00);
    check_value("snd_irqn", 24'(snd_irqn), 24'h0);
    read_check(24'hc40004, 16'hff7f);
    write_io(24'hc40004, 8'h80);
    check_value("snd_irqn", 24'(snd_irqn), 24'h1);
    read_check(24'hc40004, 16'hffff);
    write_io(24'hc40006, 8'h92);
    read_check(24'hc40006, 16'hff92);
    report_test("ppi writes", e0);
endtask

task automatic test_vblank_irq();
    logic [15:0] d;
    logic [7:0]  s;
    int          n;
    int          e0;
    int          v;
    e0 = err_cnt;
    for (v = 0; v < 262; v++) begin
        @(posedge clk);
        #2;
        vdump  = 9'(v);
        hstart = 1'b1;
        @(posedge clk);
        #1;
        // low from line 223 on, until acknowledged
        check_value("ipl2_n", 24'(ipl2_n), (v >= 223) ? 24'h0 : 24'h1);
        #1 hstart = 1'b0;
    end
    bus_cycle(24'hfffff4, 1'b1, 16'h0, 3'b111, d, s, n);   // level 2 acknowledge
    check_value("ipl2_n", 24'(ipl2_n), 24'h1);
    vdump = 9'd0;
    report_test("vblank interrupt", e0);
endtask

`endif

// ==== tests/tb_s16_main.sv ====
// main cpu bus testbench
`timescale 1ns/1ps

module tb_s16_main import s16_pkg::*; ();

    localparam int CYCLE_LIMIT = 4000;      // sweep plus all bus cycles, with margin
    localparam logic [15:0] CHR_TAG = 16'hc4a1;
    localparam logic [15:0] OBJ_TAG = 16'h0b1e;
    localparam logic [15:0] PAL_TAG = 16'h9a1e;

    logic        clk;
    logic        rst;
    bus_req_t    bus;
    logic [8:0]  vdump;
    logic        hstart;
    logic [15:0] ram_data;
    logic [15:0] rom_data;
    logic [15:0] chr_dout;
    logic [15:0] obj_dout;
    logic [15:0] pal_dout;
    logic        rom_ok = 1'b0;
    logic        ram_ok = 1'b0;
    cab_in_t     cab;
    logic        snd_ack;
    chip_sel_t   sel;
    logic [16:0] rom_addr;
    logic [11:0] ram_addr;
    logic [15:0] cpu_din;
    logic        dtack_n;
    logic        ipl2_n;
    logic [7:0]  snd_latch;
    logic        snd_irqn;
    logic        flip;

    integer seed = 32'h8880_edbe;
    int     err_cnt = 0;
    int     test_cnt = 0;
    int     fail_cnt = 0;
    int     cycle_cnt = 0;
    int     mem_delay = 0;     // ready delay of the current bus cycle
    int     wait_cnt = 0;

    // data patterns over the whole word address
    function automatic logic [15:0] rom_word(input logic [16:0] a);
        rom_word = a[15:0] ^ {a[16], 15'h2a55};
    endfunction

    function automatic logic [15:0] ram_word(input logic [11:0] a);
        ram_word = {~a[3:0], a};
    endfunction

    s16_main dut0 (.*);

    assign rom_data = rom_word(rom_addr);
    assign ram_data = ram_word(ram_addr);   // vram shares the ram port
    assign chr_dout = CHR_TAG;
    assign obj_dout = OBJ_TAG;
    assign pal_dout = PAL_TAG;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ready comes mem_delay cycles after the select
    always @(posedge clk) begin
        #2;
        if (sel.rom || sel.ram || sel.vram) begin
            if (wait_cnt >= mem_delay) begin
                rom_ok = sel.rom;
                ram_ok = sel.ram | sel.vram;
            end
            wait_cnt++;
        end else begin
            wait_cnt = 0;
            rom_ok   = 1'b0;
            ram_ok   = 1'b0;
        end
    end

    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("run stopped after %0d cycles, a test hung", cycle_cnt);
        $display("TESTBENCH FAILED");
        $finish;
    end

    `include "tb_s16_tasks.svh"

    initial begin
        rst      = 1'b1;
        bus      = '0;
        bus.as_n = 1'b1;
        bus.uds_n = 1'b1;
        bus.lds_n = 1'b1;
        bus.rnw  = 1'b1;
        bus.fc   = 3'b101;
        vdump    = 9'd0;
        hstart   = 1'b0;
        cab      = '1;          // cabinet inputs idle high
        snd_ack  = 1'b0;
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;

        test_reset();
        test_mem_reads();
        test_memory_map();
        test_cabinet_reads();
        test_ppi_writes();
        test_vblank_irq();

        $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
